// ==== verilog/tlp_params.svh ====
/*
 * TLP stream parameters
 * Channel count, per-channel payload width and the upper AFU ID
 */

`ifndef TLP_PARAMS_SVH
`define TLP_PARAMS_SVH

// Channels carried side by side in one stream beat
`define TLP_NUM_CH 2

// Payload bits per channel, eight DW
`define TLP_CH_PW 256

// Upper half of the AFU ID, returned at feature offset 0x10
`define AFU_ID_H 64'hd15ab1ed00000000

`endif

// ==== verilog/tlp_pkg.sv ====
/*
 * TLP types for the host channel tie-off
 * Header layouts, stream beat structs and format/type helpers
 */

`include "tlp_params.svh"

package tlp_pkg;

    typedef logic [7:0] t_fmttype;

    localparam t_fmttype FMTTYPE_MRD32 = 8'h00;
    localparam t_fmttype FMTTYPE_MRD64 = 8'h20;
    localparam t_fmttype FMTTYPE_MWR32 = 8'h40;
    localparam t_fmttype FMTTYPE_MWR64 = 8'h60;
    localparam t_fmttype FMTTYPE_CPLD  = 8'h4a;

    // First header DW, common to requests and completions
    typedef struct packed {
        t_fmttype    fmttype;
        logic [13:0] rsvd0;
        logic [9:0]  length;
    } t_tlp_hdr_dw0;

    // Memory request, 4 DW
    typedef struct packed {
        t_tlp_hdr_dw0 dw0;
        logic [15:0]  requester_id;
        logic [7:0]   tag;
        logic [3:0]   last_be;
        logic [3:0]   first_be;
        logic [31:0]  addr;
        // Low address DW in the 64-bit form
        logic [31:0]  lsb_addr;
    } t_mem_req_hdr;

    // Completion, padded to the request header size
    typedef struct packed {
        t_tlp_hdr_dw0 dw0;
        logic [15:0]  completer_id;
        logic [2:0]   status;
        logic         bcm;
        logic [11:0]  byte_count;
        logic [15:0]  requester_id;
        logic [7:0]   tag;
        logic         rsvd1;
        logic [6:0]   lower_addr;
        logic [31:0]  rsvd2;
    } t_cpl_hdr;

    typedef struct packed {
        logic                  valid;
        logic                  sop;
        logic                  eop;
        logic [127:0]          hdr;
        logic [`TLP_CH_PW-1:0] payload;
    } t_tlp_ch;

    typedef t_tlp_ch [`TLP_NUM_CH-1:0] t_tlp_beat;

    // Fmt bit 0 set means a 4 DW header with a 64-bit address
    function automatic logic is_addr64(input t_fmttype ft);
        return ft[5];
    endfunction

    function automatic logic is_mrd(input t_fmttype ft);
        return (ft == FMTTYPE_MRD32) || (ft == FMTTYPE_MRD64);
    endfunction

endpackage

// ==== verilog/axis_skid_buffer.sv ====
/*
 * Valid/ready skid buffer
 * Main and skid registers with a registered input ready, full throughput
 */

`timescale 1ns/1ps

module axis_skid_buffer #(
    parameter type T_PAYLOAD = logic
) (
    input  logic     clk,
    input  logic     reset_n,

    input  logic     in_valid,
    input  T_PAYLOAD in_data,
    output logic     in_ready,

    output logic     out_valid,
    output T_PAYLOAD out_data,
    input  logic     out_ready
);

    T_PAYLOAD skid_data;
    logic     skid_valid;
    logic     skid_valid_nxt;
    logic     in_fire;
    logic     main_load;

    assign in_fire = in_valid && in_ready;

    // Main register is free when empty or being drained this cycle
    assign main_load = !out_valid || out_ready;

    always_comb
    begin
        skid_valid_nxt = skid_valid;
        if (main_load)
            skid_valid_nxt = 1'b0;
        else if (in_fire)
            skid_valid_nxt = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end
        else
        begin
            if (main_load)
                out_valid <= skid_valid || in_fire;
            skid_valid <= skid_valid_nxt;
            // Ready only depends on skid occupancy, never on out_ready directly
            in_ready   <= !skid_valid_nxt;
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (main_load)
        begin
            if (skid_valid)
                out_data <= skid_data;
            else if (in_fire)
                out_data <= in_data;
        end
        else if (in_fire)
        begin
            skid_data <= in_data;
        end
    end

endmodule

// ==== verilog/mmio_req_capture.sv ====
/*
 * MMIO request capture
 * Finds a single-beat request on the RX stream and holds it until retired
 */

`timescale 1ns/1ps

`include "tlp_params.svh"

module mmio_req_capture (
    input  logic                 clk,
    input  logic                 reset_n,

    input  logic                 cap_valid,
    input  tlp_pkg::t_tlp_beat   cap_beat,
    output logic                 cap_ready,

    input  logic                 cpl_done,
    output logic                 req_pending,
    output tlp_pkg::t_mem_req_hdr req_hdr
);

    import tlp_pkg::*;

    logic         hit;
    t_mem_req_hdr hit_hdr;

    // The stream stalls while a request is held
    assign cap_ready = !req_pending;

    // Walk channels from the top down so the lowest match wins
    always_comb
    begin
        hit     = 1'b0;
        hit_hdr = '0;
        for (int c = `TLP_NUM_CH - 1; c >= 0; c--)
        begin
            if (cap_beat[c].valid && cap_beat[c].sop && cap_beat[c].eop)
            begin
                hit     = 1'b1;
                hit_hdr = t_mem_req_hdr'(cap_beat[c].hdr);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            req_pending <= 1'b0;
        end
        else if (cap_valid && cap_ready)
        begin
            // Beats with no complete packet are simply dropped
            req_pending <= hit;
        end
        else if (cpl_done)
        begin
            req_pending <= 1'b0;
        end
    end

    // Held header, only loaded on an accepted beat with a match
    always_ff @(posedge clk)
    begin
        if (cap_valid && cap_ready && hit)
            req_hdr <= hit_hdr;
    end

endmodule

// ==== verilog/afu_feature_regs.sv ====
/*
 * AFU feature registers
 * Read-only DFH and AFU ID high, selected by qword offset
 */

`timescale 1ns/1ps

`include "tlp_params.svh"

module afu_feature_regs (
    input  logic        clk,
    input  logic        reset_n,

    input  logic [3:0]  reg_qword_addr,
    output logic [63:0] reg_rdata
);

    // DFH with feature type AFU and end-of-list set
    localparam logic [63:0] DFH_VALUE = {4'h1, 19'h0, 1'b1, 40'h0};

    localparam logic [3:0] QW_DFH      = 4'h0;
    localparam logic [3:0] QW_AFU_ID_H = 4'h2;

    logic [63:0] dfh_q;
    logic [63:0] afu_id_h_q;

    // Contents are set by reset and held afterwards
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            dfh_q      <= DFH_VALUE;
            afu_id_h_q <= `AFU_ID_H;
        end
    end

    always_comb
    begin
        case (reg_qword_addr)
            QW_DFH:      reg_rdata = dfh_q;
            QW_AFU_ID_H: reg_rdata = afu_id_h_q;
            // Unmapped offsets read as zero
            default:     reg_rdata = '0;
        endcase
    end

endmodule

// ==== verilog/cpl_builder.sv ====
/*
 * Completion builder
 * Forms a CplD beat from the held read request and the register data
 */

`timescale 1ns/1ps

`include "tlp_params.svh"

module cpl_builder (
    input  logic                  req_pending,
    input  tlp_pkg::t_mem_req_hdr req_hdr,

    output logic [3:0]            reg_qword_addr,
    input  logic [63:0]           reg_rdata,

    output logic                  cpl_valid,
    output tlp_pkg::t_tlp_beat    cpl_beat,
    input  logic                  cpl_ready,
    output logic                  cpl_done
);

    import tlp_pkg::*;

    // DW that fit in one channel's payload
    localparam logic [9:0] CH_DW = 10'(`TLP_CH_PW / 32);

    t_cpl_hdr    cpl_hdr;
    logic        is_read;
    logic        eop_ch0;
    logic [63:0] cpl_data;

    assign is_read   = is_mrd(req_hdr.dw0.fmttype);
    assign cpl_valid = req_pending && is_read;

    // Writes retire immediately, reads once the completion is taken
    assign cpl_done  = req_pending && (!is_read || cpl_ready);

    always_comb
    begin
        cpl_hdr                  = '0;
        cpl_hdr.dw0.fmttype      = FMTTYPE_CPLD;
        cpl_hdr.dw0.length       = req_hdr.dw0.length;
        cpl_hdr.requester_id     = req_hdr.requester_id;
        cpl_hdr.tag              = req_hdr.tag;
        cpl_hdr.byte_count       = {req_hdr.dw0.length, 2'b00};
        cpl_hdr.lower_addr[6:2]  = is_addr64(req_hdr.dw0.fmttype) ?
                                   req_hdr.lsb_addr[6:2] : req_hdr.addr[6:2];
    end

    assign reg_qword_addr = cpl_hdr.lower_addr[6:3];
    assign eop_ch0        = req_hdr.dw0.length <= CH_DW;

    // 4-byte read of the upper half lands in the low DW
    always_comb
    begin
        cpl_data = reg_rdata;
        if (cpl_hdr.lower_addr[2])
            cpl_data[31:0] = reg_rdata[63:32];
    end

    always_comb
    begin
        cpl_beat                  = '0;
        cpl_beat[0].valid         = cpl_valid;
        cpl_beat[0].sop           = cpl_valid;
        cpl_beat[0].eop           = cpl_valid && eop_ch0;
        cpl_beat[0].hdr           = cpl_hdr;
        cpl_beat[0].payload[63:0] = cpl_data;
        // Longer completions end on the second channel
        cpl_beat[1].valid         = cpl_valid && !eop_ch0;
        cpl_beat[1].eop           = cpl_valid && !eop_ch0;
    end

endmodule

// ==== verilog/mmio_tie_off_top.sv ====
/*
 * Host channel MMIO tie-off
 * Consumes RX TLPs and answers memory reads from the feature registers
 */

`timescale 1ns/1ps

module mmio_tie_off_top (
    input  logic               clk,
    input  logic               reset_n,

    input  logic               rx_valid,
    input  tlp_pkg::t_tlp_beat rx_beat,
    output logic               rx_ready,

    output logic               tx_valid,
    output tlp_pkg::t_tlp_beat tx_beat,
    input  logic               tx_ready
);

    import tlp_pkg::*;

    logic         cap_valid;
    t_tlp_beat    cap_beat;
    logic         cap_ready;
    logic         req_pending;
    t_mem_req_hdr req_hdr;
    logic [3:0]   reg_qword_addr;
    logic [63:0]  reg_rdata;
    logic         cpl_valid;
    t_tlp_beat    cpl_beat;
    logic         cpl_ready;
    logic         cpl_done;

    // RX side timing stage
    axis_skid_buffer #(.T_PAYLOAD(t_tlp_beat)) i_rx_skid (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (rx_valid),
        .in_data   (rx_beat),
        .in_ready  (rx_ready),
        .out_valid (cap_valid),
        .out_data  (cap_beat),
        .out_ready (cap_ready)
    );

    mmio_req_capture i_capture (
        .clk         (clk),
        .reset_n     (reset_n),
        .cap_valid   (cap_valid),
        .cap_beat    (cap_beat),
        .cap_ready   (cap_ready),
        .cpl_done    (cpl_done),
        .req_pending (req_pending),
        .req_hdr     (req_hdr)
    );

    afu_feature_regs i_regs (
        .clk            (clk),
        .reset_n        (reset_n),
        .reg_qword_addr (reg_qword_addr),
        .reg_rdata      (reg_rdata)
    );

    cpl_builder i_builder (
        .req_pending    (req_pending),
        .req_hdr        (req_hdr),
        .reg_qword_addr (reg_qword_addr),
        .reg_rdata      (reg_rdata),
        .cpl_valid      (cpl_valid),
        .cpl_beat       (cpl_beat),
        .cpl_ready      (cpl_ready),
        .cpl_done       (cpl_done)
    );

    // Completions toward the host
    axis_skid_buffer #(.T_PAYLOAD(t_tlp_beat)) i_tx_skid (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (cpl_valid),
        .in_data   (cpl_beat),
        .in_ready  (cpl_ready),
        .out_valid (tx_valid),
        .out_data  (tx_beat),
        .out_ready (tx_ready)
    );

endmodule

// ==== verif/mmio_tie_off_props.sv ====
/*
 * Stream properties for the MMIO tie-off
 * Checks TX hold under back-pressure, completion type and known valids
 */

`timescale 1ns/1ps

module mmio_tie_off_props (
    input logic               clk,
    input logic               reset_n,
    input logic               rx_valid,
    input logic               tx_valid,
    input logic               tx_ready,
    input tlp_pkg::t_tlp_beat tx_beat
);

    import tlp_pkg::*;

    t_cpl_hdr    tx_hdr;

    // Number of failed properties so far
    int unsigned fail_count = 0;

    assign tx_hdr = t_cpl_hdr'(tx_beat[0].hdr);

    // A stalled beat stays on the bus unchanged
    a_tx_hold: assert property (@(posedge clk) disable iff (!reset_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
        else
        begin
            fail_count++;
            $error("tx beat changed while tx_ready was low");
        end

    a_tx_cpld: assert property (@(posedge clk) disable iff (!reset_n)
        tx_valid |-> tx_hdr.dw0.fmttype == FMTTYPE_CPLD)
        else
        begin
            fail_count++;
            $error("tx beat is not a CplD");
        end

    a_valid_known: assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown(tx_valid) && !$isunknown(rx_valid))
        else
        begin
            fail_count++;
            $error("rx_valid or tx_valid is unknown");
        end

endmodule

// ==== verif/mmio_tie_off_tb.sv ====
/*
 * Testbench for the MMIO tie-off
 * Sends requests from a case file and checks each completion in order
 */

`timescale 1ns/1ps

module mmio_tie_off_tb;

    import tlp_pkg::*;

    typedef struct packed {
        t_fmttype    ft;
        logic [9:0]  len;
        logic [15:0] rid;
        logic [7:0]  tag;
        logic [31:0] addr;
        logic [31:0] lsb;
        logic [1:0]  ch;
        logic        stall;
        logic        resp;
        logic [63:0] data;
        logic        eop_ch;
    } t_case;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        rx_valid;
    t_tlp_beat   rx_beat;
    logic        rx_ready;
    logic        tx_valid;
    t_tlp_beat   tx_beat;
    logic        tx_ready = 1'b0;
    t_case       cases[$];
    int          exp_q[$];
    int          exp_idx = 0;
    int          cycle_cnt = 0;
    int          timeout_cycles = 100;
    logic        stall_en = 1'b0;
    logic [31:0] rnd;

    mmio_tie_off_top i_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx_valid (rx_valid),
        .rx_beat  (rx_beat),
        .rx_ready (rx_ready),
        .tx_valid (tx_valid),
        .tx_beat  (tx_beat),
        .tx_ready (tx_ready)
    );

    bind mmio_tie_off_top mmio_tie_off_props i_props (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx_valid (rx_valid),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_beat  (tx_beat)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_cpl_hdr(input string name, input t_cpl_hdr got, input t_cpl_hdr exp);
        if (got !== exp)
        begin
            $display("** Error %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_payload(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("** Error %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // Completion header as the request asks for it
    function automatic t_cpl_hdr expected_cpl_hdr(input t_case c);
        t_cpl_hdr    h;
        logic [31:0] a;
        a                = (c.ft == FMTTYPE_MRD64) ? c.lsb : c.addr;
        h                = '0;
        h.dw0.fmttype    = FMTTYPE_CPLD;
        h.dw0.length     = c.len;
        h.byte_count     = 12'(c.len * 4);
        h.requester_id   = c.rid;
        h.tag            = c.tag;
        h.lower_addr     = {a[6:2], 2'b00};
        return h;
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        int          ch;
        int          stall;
        int          resp;
        int          eop;
        string       line;
        t_case       c;
        logic [31:0] f[6];
        logic [63:0] data;
        fd = $fopen("verif/mmio_tie_off_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the case file verif/mmio_tie_off_cases.txt");
            abort_run();
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%h %h %h %h %h %h %d %d %d %h %d", f[0], f[1], f[2],
                            f[3], f[4], f[5], ch, stall, resp, data, eop);
                if (n != 11)
                begin
                    $display("Malformed line in the case file: %s", line);
                    abort_run();
                end
                else
                begin
                    c = {f[0][7:0], f[1][9:0], f[2][15:0], f[3][7:0], f[4], f[5],
                         ch[1:0], stall[0], resp[0], data, eop[0]};
                    cases.push_back(c);
                    if (c.resp)
                        exp_q.push_back(cases.size() - 1);
                end
            end
            $fclose(fd);
        end
    endtask

    // Holds one beat until the RX side takes it
    task automatic send_beat(input t_tlp_beat beat);
        rx_beat  = beat;
        rx_valid = 1'b1;
        @(negedge clk);
        while (!rx_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
        rx_beat  = '0;
    endtask

    task automatic send_case(input t_case c);
        t_mem_req_hdr hdr;
        t_tlp_beat    beat;
        hdr              = '0;
        hdr.dw0.fmttype  = c.ft;
        hdr.dw0.length   = c.len;
        hdr.requester_id = c.rid;
        hdr.tag          = c.tag;
        hdr.first_be     = 4'hf;
        hdr.last_be      = (c.len > 1) ? 4'hf : 4'h0;
        hdr.addr         = c.addr;
        hdr.lsb_addr     = c.lsb;
        beat             = '0;
        if (c.ch == 2'd2)
        begin
            // Header beat without eop, then a data beat that closes the packet
            beat[0].valid = 1'b1;
            beat[0].sop   = 1'b1;
            beat[0].hdr   = hdr;
            send_beat(beat);
            beat          = '0;
            beat[0].valid = 1'b1;
            beat[0].eop   = 1'b1;
            send_beat(beat);
        end
        else
        begin
            beat[c.ch[0]].valid = 1'b1;
            beat[c.ch[0]].sop   = 1'b1;
            beat[c.ch[0]].eop   = 1'b1;
            beat[c.ch[0]].hdr   = hdr;
            send_beat(beat);
        end
    endtask

    // Random back-pressure while the current case asks for it
    initial
    begin
        rnd = $urandom(56651);
        forever
        begin
            @(posedge clk);
            #1;
            rnd      = $urandom();
            tx_ready = stall_en ? rnd[0] : 1'b1;
        end
    end

    // Completions are compared in the order the reads were sent
    always @(negedge clk)
    begin
        if (reset_n && tx_valid && tx_ready)
        begin
            if (exp_idx < exp_q.size())
            begin
                check_flag("tx_beat[0].valid", tx_beat[0].valid, 1'b1);
                check_flag("tx_beat[0].sop", tx_beat[0].sop, 1'b1);
                check_cpl_hdr("tx_beat[0].hdr", t_cpl_hdr'(tx_beat[0].hdr),
                              expected_cpl_hdr(cases[exp_q[exp_idx]]));
                check_payload("tx_beat[0].payload[63:0]", tx_beat[0].payload[63:0],
                              cases[exp_q[exp_idx]].data);
                check_flag("tx_beat[0].eop", tx_beat[0].eop, !cases[exp_q[exp_idx]].eop_ch);
                check_flag("tx_beat[1].valid", tx_beat[1].valid,
                           cases[exp_q[exp_idx]].eop_ch);
                check_flag("tx_beat[1].eop", tx_beat[1].eop, cases[exp_q[exp_idx]].eop_ch);
                exp_idx++;
            end
            else
            begin
                $display("Completion arrived with no read outstanding");
                abort_run();
            end
        end
    end

    // Stream properties watched by the bound checker
    always @(negedge clk)
    begin
        if (i_dut.i_props.fail_count != 0)
        begin
            $display("A stream property in the bound checker failed");
            abort_run();
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles)
        begin
            $display("Timeout after %0d cycles with %0d completions missing",
                     cycle_cnt, exp_q.size() - exp_idx);
            abort_run();
        end
    end

    initial
    begin
        rx_valid = 1'b0;
        rx_beat  = '0;
        reset_n  = 1'b0;
        load_cases();
        timeout_cycles = 40 * cases.size() + 100;
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;
        foreach (cases[i])
        begin
            stall_en = cases[i].stall;
            send_case(cases[i]);
        end
        while (exp_idx < exp_q.size())
            @(posedge clk);
        // Quiet period to catch any extra completion
        repeat (20) @(negedge clk);
        if (i_dut.i_props.fail_count == 0)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            abort_run();
        end
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/tlp_pkg.sv
verilog/axis_skid_buffer.sv
verilog/mmio_req_capture.sv
verilog/afu_feature_regs.sv
verilog/cpl_builder.sv
verilog/mmio_tie_off_top.sv
verif/mmio_tie_off_props.sv
verif/mmio_tie_off_tb.sv

// ==== Makefile ====
# Verilator build and run for the MMIO tie-off
TOP := mmio_tie_off_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f verilog/*.sv verilog/*.svh verif/*.sv
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/mmio_tie_off_cases.txt ====
# fmttype len req_id tag addr lsb_addr ch(0/1, 2=two beats) stall | resp data[63:0] eop_ch
# All fields hex except ch, stall, resp and eop_ch
00 002 0a01 11 00000000 00000000 0 0 1 1000010000000000 0
20 002 0a01 12 00000001 00000010 0 0 1 d15ab1ed00000000 0
20 001 0a01 13 00000000 00000014 0 0 1 d15ab1edd15ab1ed 0
00 002 0a02 14 00000008 00000000 0 0 1 0000000000000000 0
00 010 0a02 15 00000040 00000000 0 0 1 0000000000000000 1
20 008 0a02 16 00000000 00000038 0 0 1 0000000000000000 0
40 001 0a03 17 00000000 00000000 0 0 0 0000000000000000 0
00 002 0a03 18 00000000 00000000 2 0 0 0000000000000000 0
60 002 0a03 19 00000000 00000010 1 0 0 0000000000000000 0
00 002 0a03 1a 00000000 00000000 0 0 1 1000010000000000 0
00 002 0b01 20 00000010 00000000 1 1 1 d15ab1ed00000000 0
20 001 0b01 21 00000000 00000000 1 1 1 1000010000000000 0
00 001 0b01 22 00000004 00000000 0 1 1 1000010010000100 0
40 001 0b01 23 00000000 00000000 1 1 0 0000000000000000 0
00 00c 0b01 24 00000020 00000000 1 1 1 0000000000000000 1
20 002 0b01 25 00000000 00000010 0 1 1 d15ab1ed00000000 0
